// File: hw/sram_test_pkg.sv
package sram_test_pkg;

   // word address and data geometry of both macros
   localparam int addr_w = 8;
   localparam int data_w = 32;
   // one mask bit per byte lane
   localparam int wmask_w = 4;
   localparam int byte_w = data_w / wmask_w;
   // 256 entries per macro
   localparam int num_words = 1 << addr_w;

   // chip 0 is the 1rw1r macro, chip 1 the 1rw macro
   localparam int num_chips = 2;
   localparam int chip_w = $clog2(num_chips);
   localparam logic [chip_w-1:0] chip_dual = 1'b0;
   localparam logic [chip_w-1:0] chip_single = 1'b1;

   // scan packet, shifted in msb first
   // selects and write enable are active low, as on the macro pins
   typedef struct packed {
      logic [chip_w-1:0]  chip_id;
      logic               csb0;
      logic               csb1;
      logic               web0;
      logic [wmask_w-1:0] wmask0;
      logic [addr_w-1:0]  addr0;
      logic [addr_w-1:0]  addr1;
      logic [data_w-1:0]  din0;
   } op_pkt_t;

   // 56 bits for the default geometry
   localparam int pkt_w = $bits(op_pkt_t);

   // pin-level controls of one macro for one cycle
   typedef struct packed {
      logic               csb0;
      logic               csb1;
      logic               web0;
      logic [wmask_w-1:0] wmask0;
      logic [addr_w-1:0]  addr0;
      logic [addr_w-1:0]  addr1;
      logic [data_w-1:0]  din0;
   } port_ctl_t;

   // read data of both ports, dout0 goes out first on scan
   typedef struct packed {
      logic [data_w-1:0] dout0;
      logic [data_w-1:0] dout1;
   } rd_result_t;

   // 64 bits for the default geometry
   localparam int res_w = $bits(rd_result_t);

endpackage

// File: hw/scan_decoder.sv
`timescale 1ns/1ps

module scan_decoder (
   input  logic                   clk,
   input  logic                   resetn,
   input  logic                   scan_i,
   input  logic                   scan_en_i,
   input  logic                   load_i,
   output logic                   op_valid_o,
   output sram_test_pkg::op_pkt_t op_o
);

   // serial packet register, fills from the lsb end
   logic [sram_test_pkg::pkt_w-1:0] shift_q;
   // snapshot taken on the load pulse
   logic [sram_test_pkg::pkt_w-1:0] pkt_q;
   // load delayed by one cycle, marks the decode stage
   logic load_q;

   // shift one bit per clock while scan enable is held
   // msb of the packet enters first and ends up on top
   always_ff @(posedge clk) begin
      if (!resetn) begin
         shift_q <= '0;
      end else if (scan_en_i) begin
         shift_q <= {shift_q[sram_test_pkg::pkt_w-2:0], scan_i};
      end
   end

   // strobe pipeline
   // load seen at edge n, op_valid_o high after edge n+1
   always_ff @(posedge clk) begin
      if (!resetn) begin
         load_q     <= 1'b0;
         op_valid_o <= 1'b0;
      end else begin
         load_q     <= load_i;
         op_valid_o <= load_q;
      end
   end

   // freeze the packet as soon as load is seen
   // later shifting cannot disturb an op already in flight
   always_ff @(posedge clk) begin
      if (load_i) begin
         pkt_q <= shift_q;
      end
   end

   // decode stage
   // raw bits become the typed packet handed to the executor
   // a short shift simply leaves stale bits in the upper fields
   always_ff @(posedge clk) begin
      if (load_q) begin
         op_o <= sram_test_pkg::op_pkt_t'(pkt_q);
      end
   end

endmodule

// File: hw/sram_exec.sv
`timescale 1ns/1ps

module sram_exec (
   input  logic                                                 clk,
   input  logic                                                 resetn,
   input  logic                                                 op_valid_i,
   input  sram_test_pkg::op_pkt_t                               op_i,
   output sram_test_pkg::port_ctl_t [sram_test_pkg::num_chips-1:0] ctl_o,
   output logic                                                 acc_valid_o,
   output logic [sram_test_pkg::chip_w-1:0]                     chip_o
);

   // which macro this op addresses, none when idle
   logic [sram_test_pkg::num_chips-1:0] hit;

   // per-chip selects, active low
   logic [sram_test_pkg::num_chips-1:0] csb0_q;
   logic [sram_test_pkg::num_chips-1:0] csb1_q;

   // shared address, data and write controls
   logic                              web0_q;
   logic [sram_test_pkg::wmask_w-1:0] wmask0_q;
   logic [sram_test_pkg::addr_w-1:0]  addr0_q;
   logic [sram_test_pkg::addr_w-1:0]  addr1_q;
   logic [sram_test_pkg::data_w-1:0]  din0_q;

   // access stage, in step with the controls at the macro pins
   logic                            acc_q;
   logic [sram_test_pkg::chip_w-1:0] chip_q;

   always_comb begin
      for (int c = 0; c < sram_test_pkg::num_chips; c++) begin
         hit[c] = op_valid_i && (int'(op_i.chip_id) == c);
      end
   end

   // only the addressed chip sees the packet selects
   // every other chip, and every chip when idle, stays deselected
   always_ff @(posedge clk) begin
      if (!resetn) begin
         csb0_q <= '1;
         csb1_q <= '1;
      end else begin
         for (int c = 0; c < sram_test_pkg::num_chips; c++) begin
            csb0_q[c] <= !hit[c] || op_i.csb0;
            csb1_q[c] <= !hit[c] || op_i.csb1;
         end
      end
   end

   // bus fields only move on a new op
   always_ff @(posedge clk) begin
      if (op_valid_i) begin
         web0_q   <= op_i.web0;
         wmask0_q <= op_i.wmask0;
         addr0_q  <= op_i.addr0;
         addr1_q  <= op_i.addr1;
         din0_q   <= op_i.din0;
      end
   end

   // chip id and valid travel two stages
   // the second stage lines up with dout after the macro edge
   always_ff @(posedge clk) begin
      if (!resetn) begin
         acc_q       <= 1'b0;
         chip_q      <= '0;
         acc_valid_o <= 1'b0;
         chip_o      <= '0;
      end else begin
         acc_q       <= op_valid_i;
         chip_q      <= op_i.chip_id;
         acc_valid_o <= acc_q;
         chip_o      <= chip_q;
      end
   end

   // one control bundle per macro, shared bus with private selects
   for (genvar c = 0; c < sram_test_pkg::num_chips; c++) begin : g_ctl
      assign ctl_o[c] = '{
         csb0:   csb0_q[c],
         csb1:   csb1_q[c],
         web0:   web0_q,
         wmask0: wmask0_q,
         addr0:  addr0_q,
         addr1:  addr1_q,
         din0:   din0_q
      };
   end

endmodule

// File: hw/sram_macro_model.sv
`timescale 1ns/1ps

module sram_macro_model #(
   // 1 gives the 1rw1r macro, 0 the single-port 1rw macro
   parameter bit has_read_port = 1'b1
) (
   input  logic                      clk,
   input  sram_test_pkg::port_ctl_t  ctl_i,
   output sram_test_pkg::rd_result_t dout_o
);

   // storage array, powers up cleared like a fresh test die
   logic [sram_test_pkg::data_w-1:0] mem [sram_test_pkg::num_words] = '{default: '0};

   logic [sram_test_pkg::data_w-1:0] dout0_q;
   logic [sram_test_pkg::data_w-1:0] dout1_q;

   // port 0 access decode
   logic rd0;
   logic wr0;

   assign rd0 = !ctl_i.csb0 && ctl_i.web0;
   assign wr0 = !ctl_i.csb0 && !ctl_i.web0;

   // port 0 write
   // only lanes with their mask bit set are touched
   always_ff @(posedge clk) begin
      if (wr0) begin
         for (int b = 0; b < sram_test_pkg::wmask_w; b++) begin
            if (ctl_i.wmask0[b]) begin
               mem[ctl_i.addr0][b*sram_test_pkg::byte_w +: sram_test_pkg::byte_w] <=
                  ctl_i.din0[b*sram_test_pkg::byte_w +: sram_test_pkg::byte_w];
            end
         end
      end
   end

   // port 0 read
   // deselected or writing returns zero rather than holding old data
   always_ff @(posedge clk) begin
      if (rd0) begin
         dout0_q <= mem[ctl_i.addr0];
      end else begin
         dout0_q <= '0;
      end
   end

   if (has_read_port) begin : g_port1
      // read-only port 1
      // same-address write on port 0 returns the old word
      always_ff @(posedge clk) begin
         if (!ctl_i.csb1) begin
            dout1_q <= mem[ctl_i.addr1];
         end else begin
            dout1_q <= '0;
         end
      end
   end else begin : g_no_port1
      // single-port macro, csb1 and addr1 have no pins here
      assign dout1_q = '0;
   end

   assign dout_o = '{dout0: dout0_q, dout1: dout1_q};

endmodule

// File: hw/result_capture.sv
`timescale 1ns/1ps

module result_capture (
   input  logic                                                  clk,
   input  logic                                                  resetn,
   input  logic                                                  acc_valid_i,
   input  logic [sram_test_pkg::chip_w-1:0]                      chip_i,
   input  sram_test_pkg::rd_result_t [sram_test_pkg::num_chips-1:0] dout_i,
   input  logic                                                  scan_en_i,
   output logic                                                  scan_o,
   output logic                                                  done_o
);

   // capture and shift-out register, dout0 in the upper half
   logic [sram_test_pkg::res_w-1:0] shift_q;

   // result of the chip that was accessed
   sram_test_pkg::rd_result_t sel_res;

   assign sel_res = dout_i[chip_i];

   // capture wins over shifting
   // a capture during a scan-out replaces whatever was left
   // zeros fill in from the bottom as bits leave
   always_ff @(posedge clk) begin
      if (!resetn) begin
         shift_q <= '0;
      end else if (acc_valid_i) begin
         shift_q <= sel_res;
      end else if (scan_en_i) begin
         shift_q <= {shift_q[sram_test_pkg::res_w-2:0], 1'b0};
      end
   end

   // one done pulse per capture
   // back-to-back ops give back-to-back pulses
   always_ff @(posedge clk) begin
      if (!resetn) begin
         done_o <= 1'b0;
      end else begin
         done_o <= acc_valid_i;
      end
   end

   // msb is on the pin before the first shift
   // sample scan_o, then clock, for each of the 64 bits
   assign scan_o = shift_q[sram_test_pkg::res_w-1];

endmodule

// File: hw/sram_test_top.sv
`timescale 1ns/1ps

module sram_test_top (
   input  logic clk,
   input  logic resetn,
   input  logic scan_i,
   input  logic scan_en_i,
   input  logic load_i,
   output logic scan_o,
   output logic done_o
);

   // decoder to executor
   logic                   op_valid;
   sram_test_pkg::op_pkt_t op;

   // executor to macros and capture
   sram_test_pkg::port_ctl_t [sram_test_pkg::num_chips-1:0] ctl;
   logic                                                    acc_valid;
   logic [sram_test_pkg::chip_w-1:0]                        chip_q;

   // macro read data
   sram_test_pkg::rd_result_t [sram_test_pkg::num_chips-1:0] dout;

   // scan in and decode
   scan_decoder u_decoder (
      .clk        (clk),
      .resetn     (resetn),
      .scan_i     (scan_i),
      .scan_en_i  (scan_en_i),
      .load_i     (load_i),
      .op_valid_o (op_valid),
      .op_o       (op)
   );

   // per-chip controls
   sram_exec u_exec (
      .clk         (clk),
      .resetn      (resetn),
      .op_valid_i  (op_valid),
      .op_i        (op),
      .ctl_o       (ctl),
      .acc_valid_o (acc_valid),
      .chip_o      (chip_q)
   );

   // chip 0, 1rw1r 32x256
   sram_macro_model #(
      .has_read_port (1'b1)
   ) u_chip_dual (
      .clk    (clk),
      .ctl_i  (ctl[sram_test_pkg::chip_dual]),
      .dout_o (dout[sram_test_pkg::chip_dual])
   );

   // chip 1, 1rw 32x256
   sram_macro_model #(
      .has_read_port (1'b0)
   ) u_chip_single (
      .clk    (clk),
      .ctl_i  (ctl[sram_test_pkg::chip_single]),
      .dout_o (dout[sram_test_pkg::chip_single])
   );

   // capture and scan out
   result_capture u_capture (
      .clk         (clk),
      .resetn      (resetn),
      .acc_valid_i (acc_valid),
      .chip_i      (chip_q),
      .dout_i      (dout),
      .scan_en_i   (scan_en_i),
      .scan_o      (scan_o),
      .done_o      (done_o)
   );

endmodule

// File: dv/sram_test_tb.sv
`timescale 1ns/1ps

module sram_test_tb;

   // run budget of about 200 cycles per directed test
   localparam int num_tests = 6;
   localparam int cycle_limit = num_tests * 200;
   // load to done is 4 cycles
   // give up well past that
   localparam int done_wait_max = 20;
   // test addresses
   // a and b hold data from test 2 on
   localparam logic [7:0] addr_a = 8'h10;
   localparam logic [7:0] addr_b = 8'h87;
   localparam logic [7:0] addr_c = 8'hf0;

   logic clk = 1'b0;
   logic resetn;
   logic scan_i;
   logic scan_en_i;
   logic load_i;
   logic scan_o;
   logic done_o;

   integer seed = 72683;
   int cycle_count = 0;
   int n_checks = 0;
   int n_errors = 0;
   int n_failed = 0;
   int test_no = 0;

   // expected contents of both macros
   logic [31:0] ref_mem [sram_test_pkg::num_chips][sram_test_pkg::num_words];
   // selects nothing and parks the packet register between tests
   sram_test_pkg::op_pkt_t idle_pkt;

   sram_test_top DUT (
      .clk       (clk),
      .resetn    (resetn),
      .scan_i    (scan_i),
      .scan_en_i (scan_en_i),
      .load_i    (load_i),
      .scan_o    (scan_o),
      .done_o    (done_o)
   );

   // 40 ns period
   always #20 clk = ~clk;

   // hard stop for a hung run
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("timeout after %0d cycles, a test hung or ran long", cycle_count);
         $display("Test failed");
         $finish;
      end
   end

   function automatic sram_test_pkg::op_pkt_t make_pkt(
      input logic chip, input logic csb0, input logic csb1, input logic web0,
      input logic [3:0] wmask, input logic [7:0] addr0, input logic [7:0] addr1,
      input logic [31:0] din
   );
      return {chip, csb0, csb1, web0, wmask, addr0, addr1, din};
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      n_checks++;
      assert (got === exp) else begin
         $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
         n_errors++;
      end
   endtask

   // result rule on the reference memory
   // reads see the word from before this op's own write
   task automatic model_access(input sram_test_pkg::op_pkt_t p, output logic [63:0] exp);
      logic [31:0] d0;
      logic [31:0] d1;
      logic [31:0] w;
      d0 = '0;
      d1 = '0;
      if (!p.csb0 && p.web0)
         d0 = ref_mem[p.chip_id][p.addr0];
      // only chip 0 has a second port
      if (p.chip_id == sram_test_pkg::chip_dual && !p.csb1)
         d1 = ref_mem[p.chip_id][p.addr1];
      if (!p.csb0 && !p.web0) begin
         w = ref_mem[p.chip_id][p.addr0];
         for (int b = 0; b < 4; b++) begin
            if (p.wmask0[b])
               w[b*8 +: 8] = p.din0[b*8 +: 8];
         end
         ref_mem[p.chip_id][p.addr0] = w;
      end
      exp = {d0, d1};
   endtask

   // msb first
   // last bit is sampled on the next edge
   task automatic shift_packet(input sram_test_pkg::op_pkt_t p);
      for (int i = sram_test_pkg::pkt_w - 1; i >= 0; i--) begin
         @(posedge clk);
         scan_en_i <= 1'b1;
         scan_i    <= p[i];
      end
   endtask

   // one load pulse, then wait for done and measure the latency
   task automatic issue_op();
      int lat;
      @(posedge clk);
      scan_en_i <= 1'b0;
      scan_i    <= 1'b0;
      load_i    <= 1'b1;
      @(posedge clk);
      load_i <= 1'b0;
      lat = 0;
      @(negedge clk);
      while (!done_o && lat < done_wait_max) begin
         @(posedge clk);
         lat++;
         @(negedge clk);
      end
      assert (done_o) else begin
         $display("done_o never rose within %0d cycles of load_i", done_wait_max);
         n_errors++;
      end
      if (done_o)
         check_value("done_o latency", lat, 32'd4);
   endtask

   // 64 bits out on scan_o while the next packet goes in behind them
   task automatic shift_result(input sram_test_pkg::op_pkt_t next_p, output logic [63:0] got);
      logic [63:0] stream;
      stream = {{(sram_test_pkg::res_w - sram_test_pkg::pkt_w){1'b0}}, next_p};
      for (int i = sram_test_pkg::res_w - 1; i >= 0; i--) begin
         @(posedge clk);
         scan_en_i <= 1'b1;
         scan_i    <= stream[i];
         @(negedge clk);
         got[i] = scan_o;
      end
   endtask

   task automatic scan_idle();
      @(posedge clk);
      scan_en_i <= 1'b0;
      scan_i    <= 1'b0;
   endtask

   // full access with scan-out and check of both halves
   // shifted means the packet already went in with the last scan-out
   task automatic read_check(input sram_test_pkg::op_pkt_t p, input bit shifted,
                             input sram_test_pkg::op_pkt_t next_p, input string tag);
      logic [63:0] exp;
      logic [63:0] got;
      if (!shifted)
         shift_packet(p);
      model_access(p, exp);
      issue_op();
      shift_result(next_p, got);
      check_value({tag, " dout0"}, got[63:32], exp[63:32]);
      check_value({tag, " dout1"}, got[31:0], exp[31:0]);
   endtask

   // port 0 write without a scan-out
   task automatic write_word(input logic chip, input logic [3:0] mask,
                             input logic [7:0] addr, input logic [31:0] data);
      sram_test_pkg::op_pkt_t p;
      logic [63:0] dummy;
      p = make_pkt(chip, 1'b0, 1'b1, 1'b0, mask, addr, 8'h00, data);
      shift_packet(p);
      model_access(p, dummy);
      issue_op();
   endtask

   task automatic finish_test(input string name, input int errs_before);
      test_no++;
      if (n_errors == errs_before) begin
         $display("test %0d %s: ok", test_no, name);
      end else begin
         n_failed++;
         $display("test %0d %s: %0d errors", test_no, name, n_errors - errs_before);
      end
   endtask

   task automatic test_reset_state();
      int errs;
      errs = n_errors;
      @(negedge clk);
      check_value("done_o", 32'(done_o), 32'd0);
      check_value("scan_o", 32'(scan_o), 32'd0);
      read_check(make_pkt(sram_test_pkg::chip_dual, 1'b0, 1'b0, 1'b1, 4'h0, 8'h5a, 8'ha5, '0),
                 1'b0, idle_pkt, "blank read");
      scan_idle();
      finish_test("reset state", errs);
   endtask

   task automatic test_dual_port_readback();
      int errs;
      errs = n_errors;
      write_word(sram_test_pkg::chip_dual, 4'hf, addr_a, $random(seed));
      write_word(sram_test_pkg::chip_dual, 4'hf, addr_b, $random(seed));
      // both ports in the same access
      read_check(make_pkt(sram_test_pkg::chip_dual, 1'b0, 1'b0, 1'b1, 4'h0, addr_a, addr_b, '0),
                 1'b0, idle_pkt, "dual read");
      scan_idle();
      finish_test("dual port readback", errs);
   endtask

   task automatic test_partial_write();
      int errs;
      logic [3:0] m;
      errs = n_errors;
      m = 4'($random(seed));
      // keep the mask truly partial
      if (m == 4'h0 || m == 4'hf)
         m = 4'b0101;
      write_word(sram_test_pkg::chip_dual, m, addr_a, $random(seed));
      read_check(make_pkt(sram_test_pkg::chip_dual, 1'b0, 1'b0, 1'b1, 4'h0, addr_a, addr_b, '0),
                 1'b0, idle_pkt, "masked read");
      scan_idle();
      finish_test("partial write", errs);
   endtask

   task automatic test_single_port_chip();
      int errs;
      sram_test_pkg::op_pkt_t p1;
      sram_test_pkg::op_pkt_t p0;
      errs = n_errors;
      write_word(sram_test_pkg::chip_single, 4'hf, addr_a, $random(seed));
      // csb1 low on chip 1 has no port behind it
      p1 = make_pkt(sram_test_pkg::chip_single, 1'b0, 1'b0, 1'b1, 4'h0, addr_a, addr_b, '0);
      // same address on chip 0 must be untouched
      p0 = make_pkt(sram_test_pkg::chip_dual, 1'b0, 1'b1, 1'b1, 4'h0, addr_a, 8'h00, '0);
      read_check(p1, 1'b0, p0, "chip 1 read");
      read_check(p0, 1'b1, idle_pkt, "chip 0 same address");
      scan_idle();
      finish_test("single port chip", errs);
   endtask

   task automatic test_zero_halves();
      int errs;
      sram_test_pkg::op_pkt_t pa;
      sram_test_pkg::op_pkt_t pb;
      errs = n_errors;
      // port 0 overwrites the old word at b while port 1 reads a
      pa = make_pkt(sram_test_pkg::chip_dual, 1'b0, 1'b0, 1'b0, 4'hf, addr_b, addr_a,
                    $random(seed));
      // port 0 deselected on a live word while port 1 reads back the new word at b
      pb = make_pkt(sram_test_pkg::chip_dual, 1'b1, 1'b0, 1'b1, 4'h0, addr_a, addr_b, '0);
      read_check(pa, 1'b0, pb, "write with read");
      read_check(pb, 1'b1, idle_pkt, "port 0 deselected");
      scan_idle();
      finish_test("zero halves", errs);
   endtask

   // three loads on consecutive edges with scan still running
   // each load takes the register before it moves one bit on
   task automatic test_back_to_back();
      int errs;
      sram_test_pkg::op_pkt_t last;
      sram_test_pkg::op_pkt_t head;
      sram_test_pkg::op_pkt_t mid;
      logic [63:0] exp;
      logic [63:0] got;
      logic [5:0] pulses;
      errs = n_errors;
      last = make_pkt(sram_test_pkg::chip_dual, 1'b0, 1'b0, 1'b1, 4'h0, addr_a, addr_c, '0);
      // two more shifts turn head into last
      // head reads port 1 only and mid writes chip 1
      head = {2'b01, last[55:2]};
      mid = {head[54:0], last[1]};
      shift_packet(head);
      @(posedge clk);
      load_i <= 1'b1;
      scan_i <= last[1];
      @(posedge clk);
      scan_i <= last[0];
      @(posedge clk);
      scan_i <= 1'b0;
      @(posedge clk);
      load_i    <= 1'b0;
      scan_en_i <= 1'b0;
      model_access(head, exp);
      model_access(mid, exp);
      model_access(last, exp);
      // loads sampled 2, 1 and 0 edges back
      // done expected on samples 2 to 4
      pulses = '0;
      for (int e = 0; e < 6; e++) begin
         @(negedge clk);
         pulses = {pulses[4:0], done_o};
         @(posedge clk);
      end
      check_value("done_o pulse train", 32'(pulses), 32'b001110);
      shift_result(idle_pkt, got);
      check_value("third op dout0", got[63:32], exp[63:32]);
      check_value("third op dout1", got[31:0], exp[31:0]);
      scan_idle();
      finish_test("back to back", errs);
   endtask

   initial begin
      resetn    = 1'b0;
      scan_i    = 1'b0;
      scan_en_i = 1'b0;
      load_i    = 1'b0;
      idle_pkt  = make_pkt(sram_test_pkg::chip_dual, 1'b1, 1'b1, 1'b1, 4'h0, 8'h00, 8'h00, '0);
      foreach (ref_mem[c, a])
         ref_mem[c][a] = '0;
      repeat (3) @(posedge clk);
      resetn <= 1'b1;
      test_reset_state();
      test_dual_port_readback();
      test_partial_write();
      test_single_port_chip();
      test_zero_halves();
      test_back_to_back();
      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               test_no, n_failed, n_checks, n_errors);
      if (n_errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// File: sim.f
hw/sram_test_pkg.sv
hw/scan_decoder.sv
hw/sram_exec.sv
hw/sram_macro_model.sv
hw/result_capture.sv
hw/sram_test_top.sv
dv/sram_test_tb.sv

// File: Makefile
# Verilator build and run of the SRAM test chip testbench

VERILATOR  ?= verilator
FILELIST   ?= sim.f
TB_TOP     ?= sram_test_tb
RTL_TOP    ?= sram_test_top
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= -Wall
PASS_MSG   ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -o $(TB_TOP)

run: build
	@out="$$(./$(BUILD_DIR)/$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
